// File: sources.f
source/gpu_pkg.sv
source/gpu_inst_fifo.sv
source/gpu_inst_regs.sv
source/gpu_draw_rect.sv
source/gpu_pixel_writer.sv
source/gpu_core.sv
test/gpu_core_chk.sv
test/gpu_core_tb.sv

// File: Bender.yml
package:
  name: gpu_core

sources:
  - files:
      - source/gpu_pkg.sv
      - source/gpu_inst_fifo.sv
      - source/gpu_inst_regs.sv
      - source/gpu_draw_rect.sv
      - source/gpu_pixel_writer.sv
      - source/gpu_core.sv
  - target: test
    files:
      - test/gpu_core_chk.sv
      - test/gpu_core_tb.sv

// File: test/gpu_core_tb.sv
`timescale 1ns/1ps

module gpu_core_tb;

   localparam int SCREEN_W = 16;
   localparam int SCREEN_H = 8;
   localparam int PLANE    = SCREEN_W * SCREEN_H;
   // Boot clears plus four rectangles, doubled for pause, with margin.
   localparam int MAX_CYCLES = 4000;

   logic                        clk_gpu;
   logic                        reset;
   logic                        cpu_inst_valid;
   logic [gpu_pkg::INST_W-1:0]  cpu_data;
   logic                        pause;
   logic                        cpu_bp;
   logic [gpu_pkg::ADDR_W-1:0]  ram_addr;
   logic [gpu_pkg::COLOR_W-1:0] ram_wdata;
   logic                        ram_we_n;
   logic                        cmd_active;

   int   seed = 54;
   int   cycles = 0;
   logic pause_en = 1'b0;
   logic in_boot = 1'b1;
   int   boot_writes = 0;
   int   seen_writes = 0;
   int   last_hits = 0;
   int   exp_x_lo;
   int   exp_x_hi;
   int   exp_y_lo;
   int   exp_y_hi;
   int   exp_layer;
   int   exp_color;
   int   base_w;
   int   base_h;
   int   accepted;
   logic saw_bp;

   gpu_core #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H), .FIFO_DEPTH(4)) gpu_core_i (
      .clk_gpu        (clk_gpu),
      .reset          (reset),
      .cpu_inst_valid (cpu_inst_valid),
      .cpu_data       (cpu_data),
      .pause          (pause),
      .cpu_bp         (cpu_bp),
      .ram_addr       (ram_addr),
      .ram_wdata      (ram_wdata),
      .ram_we_n       (ram_we_n),
      .cmd_active     (cmd_active)
   );

   initial begin
      clk_gpu = 1'b0;
      forever #4 clk_gpu = ~clk_gpu;
   end

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("=== FAIL ===");
      $fatal(1, "run stopped at %0t", $time);
   endtask

   task automatic report_mismatch(input string name, input int got, input int exp);
      stop_on_error($sformatf("FAILED %0t %s got %0h expected %0h", $time, name, got, exp));
   endtask

   always @(posedge clk_gpu) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         stop_on_error($sformatf("timeout after %0d cycles", cycles));
      end
      if (gpu_core_i.gpu_core_chk_i.failed) begin
         stop_on_error("an assertion in gpu_core_chk failed");
      end
   end

   always @(posedge clk_gpu) begin
      if (pause_en) begin
         pause <= (($random(seed) & 3) == 0);
      end else begin
         pause <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // RAM write monitor
   ////////////////////////////////////////////////////////////

   always @(posedge clk_gpu) begin
      int px;
      int py;
      if (!reset && !ram_we_n) begin
         px = (ram_addr % PLANE) % SCREEN_W;
         py = (ram_addr % PLANE) / SCREEN_W;
         if (in_boot) begin
            // Boot clears walk both planes in address order.
            assert (ram_wdata == 0) else report_mismatch("ram_wdata", ram_wdata, 0);
            assert (ram_addr == boot_writes) else report_mismatch("ram_addr", ram_addr, boot_writes);
            boot_writes <= boot_writes + 1;
         end else begin
            assert (ram_wdata == exp_color)
               else report_mismatch("ram_wdata", ram_wdata, exp_color);
            assert (ram_addr / PLANE == exp_layer)
               else report_mismatch("ram_addr plane", ram_addr / PLANE, exp_layer);
            assert (px >= exp_x_lo && px <= exp_x_hi && py >= exp_y_lo && py <= exp_y_hi)
               else stop_on_error($sformatf("write at %0t to x %0d y %0d is outside the rectangle",
                                            $time, px, py));
            seen_writes <= seen_writes + 1;
            if (px == exp_x_hi && py == exp_y_hi) begin
               last_hits <= last_hits + 1;
            end
         end
      end
   end

   function automatic logic [gpu_pkg::INST_W-1:0] encode(input gpu_pkg::gpu_cmd_e cmd,
                                                         input int payload);
      logic [gpu_pkg::INST_W-1:0] inst;
      inst = gpu_pkg::INST_W'(payload);
      inst[gpu_pkg::CMD_MSB:gpu_pkg::CMD_LSB] = cmd;
      return inst;
   endfunction

   task automatic send_inst(input logic [gpu_pkg::INST_W-1:0] inst);
      cpu_inst_valid <= 1'b1;
      cpu_data       <= inst;
      @(posedge clk_gpu);
      while (cpu_bp) begin
         @(posedge clk_gpu);
      end
      cpu_inst_valid <= 1'b0;
   endtask

   // Idle means no command, no pause and no write left in the stage.
   task automatic settle;
      while (cmd_active) begin
         @(posedge clk_gpu);
      end
      pause_en <= 1'b0;
      @(posedge clk_gpu);
      while (pause || cmd_active || !ram_we_n) begin
         @(posedge clk_gpu);
      end
      pause_en <= 1'b1;
   endtask

   task automatic finish_draw;
      while (!cmd_active) begin
         @(posedge clk_gpu);
      end
      settle;
   endtask

   task automatic load_rect(input int xa, input int ya, input int xb, input int yb,
                            input int lyr, input int col);
      exp_x_lo  = (xa < xb) ? xa : xb;
      exp_x_hi  = (xa < xb) ? xb : xa;
      exp_x_hi  = (exp_x_hi > SCREEN_W - 1) ? SCREEN_W - 1 : exp_x_hi;
      exp_y_lo  = (ya < yb) ? ya : yb;
      exp_y_hi  = (ya < yb) ? yb : ya;
      exp_layer = lyr;
      exp_color = col;
      send_inst(encode(gpu_pkg::CMD_SET_P1, (xa << gpu_pkg::P_X_LSB) | (ya << gpu_pkg::P_Y_LSB)));
      send_inst(encode(gpu_pkg::CMD_SET_P2, (xb << gpu_pkg::P_X_LSB) | (yb << gpu_pkg::P_Y_LSB)));
      send_inst(encode(gpu_pkg::CMD_SET_COLOR, col));
      send_inst(encode(gpu_pkg::CMD_SET_LAYER, lyr));
      send_inst(encode(gpu_pkg::CMD_DRAW_RECT, 0));
   endtask

   task automatic run_rect(input int xa, input int ya, input int xb, input int yb,
                           input int lyr, input int col);
      int area;
      base_w = seen_writes;
      load_rect(xa, ya, xb, yb, lyr, col);
      finish_draw;
      area = (exp_x_hi - exp_x_lo + 1) * (exp_y_hi - exp_y_lo + 1);
      assert (seen_writes - base_w == area)
         else report_mismatch("write count", seen_writes - base_w, area);
   endtask

   initial begin
      reset          = 1'b1;
      cpu_inst_valid = 1'b0;
      cpu_data       = '0;
      pause          = 1'b0;
      repeat (16) @(posedge clk_gpu);
      reset    <= 1'b0;
      pause_en <= 1'b1;

      // Both boot clears.
      while (cpu_bp) begin
         @(posedge clk_gpu);
      end
      settle;
      assert (boot_writes == 2 * PLANE)
         else report_mismatch("boot writes", boot_writes, 2 * PLANE);
      in_boot <= 1'b0;

      run_rect(3, 2, 9, 6, 0, 16'hF81F);
      // Corners given in reverse order.
      run_rect(14, 7, 5, 1, 1, 16'h07E0);
      run_rect(12, 0, 20, 3, 1, 16'h001F);

      ////////////////////////////////////////////////////////////
      // Back-pressure behind a full-screen rectangle
      ////////////////////////////////////////////////////////////

      base_w   = seen_writes;
      base_h   = last_hits;
      accepted = 0;
      saw_bp   = 1'b0;
      load_rect(0, 0, SCREEN_W - 1, SCREEN_H - 1, 0, 16'hFFFF);
      repeat (8) begin
         cpu_inst_valid <= 1'b1;
         cpu_data       <= encode(gpu_pkg::CMD_DRAW_RECT, 0);
         @(posedge clk_gpu);
         if (cpu_bp) begin
            saw_bp = 1'b1;
         end else begin
            accepted++;
         end
      end
      cpu_inst_valid <= 1'b0;
      // Queue has drained once the last rectangle's final pixel is written.
      while (last_hits - base_h < accepted + 1) begin
         @(posedge clk_gpu);
      end
      assert (!cmd_active) else report_mismatch("cmd_active", cmd_active, 0);
      settle;
      assert (saw_bp) else stop_on_error("cpu_bp never rose while the FIFO was full");
      assert (last_hits - base_h == accepted + 1)
         else report_mismatch("rectangles", last_hits - base_h, accepted + 1);
      assert (seen_writes - base_w == PLANE * (accepted + 1))
         else report_mismatch("write count", seen_writes - base_w, PLANE * (accepted + 1));

      if (gpu_core_i.gpu_core_chk_i.failed) begin
         stop_on_error("an assertion in gpu_core_chk failed");
      end else begin
         $display("=== PASS ===");
         $finish;
      end
   end

endmodule

// File: test/gpu_core_chk.sv
`timescale 1ns/1ps

module gpu_core_chk #(
   parameter int SCREEN_W = 320,
   parameter int SCREEN_H = 240
) (
   input logic                       clk_gpu,
   input logic                       reset,
   input logic                       pause,
   input logic                       cpu_bp,
   input logic                       cmd_active,
   input logic                       ram_we_n,
   input logic [gpu_pkg::ADDR_W-1:0] ram_addr
);

   localparam int PLANE = SCREEN_W * SCREEN_H;

   logic failed = 1'b0;
   int   boot_writes;

   // Writes since reset, saturating once both planes are cleared.
   always_ff @(posedge clk_gpu) begin
      if (reset) begin
         boot_writes <= 0;
      end else if (!ram_we_n && boot_writes < 2 * PLANE) begin
         boot_writes <= boot_writes + 1;
      end
   end

   reset_we: assert property (@(posedge clk_gpu) reset |=> ram_we_n)
      else begin
         failed = 1'b1;
         $error("FAILED %0t ram_we_n got %b expected 1", $time, $sampled(ram_we_n));
      end

   pause_we: assert property (@(posedge clk_gpu) disable iff (reset) pause |-> ram_we_n)
      else begin
         failed = 1'b1;
         $error("FAILED %0t ram_we_n got %b expected 1 under pause", $time, $sampled(ram_we_n));
      end

   // The last boot write may still sit in the write stage when cpu_bp drops.
   boot_bp: assert property (@(posedge clk_gpu) disable iff (reset)
                             boot_writes < 2 * PLANE - 1 |-> cpu_bp)
      else begin
         failed = 1'b1;
         $error("FAILED %0t cpu_bp got %b expected 1", $time, $sampled(cpu_bp));
      end

   boot_active: assert property (@(posedge clk_gpu) $fell(reset) |-> cmd_active)
      else begin
         failed = 1'b1;
         $error("FAILED %0t cmd_active got %b expected 1", $time, $sampled(cmd_active));
      end

   addr_range: assert property (@(posedge clk_gpu) disable iff (reset)
                                !ram_we_n |-> ram_addr < 2 * PLANE)
      else begin
         failed = 1'b1;
         $error("FAILED %0t ram_addr got %0h expected below %0h",
                $time, $sampled(ram_addr), 2 * PLANE);
      end

endmodule

bind gpu_core gpu_core_chk #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) gpu_core_chk_i (
   .clk_gpu    (clk_gpu),
   .reset      (reset),
   .pause      (pause),
   .cpu_bp     (cpu_bp),
   .cmd_active (cmd_active),
   .ram_we_n   (ram_we_n),
   .ram_addr   (ram_addr)
);

// File: source/gpu_core.sv
`timescale 1ns/1ps

module gpu_core #(
   parameter int SCREEN_W   = 320,
   parameter int SCREEN_H   = 240,
   parameter int FIFO_DEPTH = 64
) (
   input  logic                         clk_gpu,
   input  logic                         reset,
   input  logic                         cpu_inst_valid,
   input  logic [gpu_pkg::INST_W-1:0]   cpu_data,
   input  logic                         pause,
   output logic                         cpu_bp,
   output logic [gpu_pkg::ADDR_W-1:0]   ram_addr,
   output logic [gpu_pkg::COLOR_W-1:0]  ram_wdata,
   output logic                         ram_we_n,
   output logic                         cmd_active
);

   logic                        fifo_read;
   logic [gpu_pkg::INST_W-1:0]  fifo_data;
   logic                        fifo_empty;
   logic                        fifo_full;
   logic                        rect_start;
   logic                        rect_done;
   logic [gpu_pkg::X_W-1:0]     x1;
   logic [gpu_pkg::Y_W-1:0]     y1;
   logic [gpu_pkg::X_W-1:0]     x2;
   logic [gpu_pkg::Y_W-1:0]     y2;
   logic [gpu_pkg::COLOR_W-1:0] color;
   gpu_pkg::gpu_layer_e         layer;
   logic                        pix_valid;
   logic [gpu_pkg::X_W-1:0]     pix_x;
   logic [gpu_pkg::Y_W-1:0]     pix_y;

   gpu_inst_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) gpu_inst_fifo_i (
      .clk_gpu (clk_gpu),
      .reset   (reset),
      .write   (cpu_inst_valid),
      .wdata   (cpu_data),
      .read    (fifo_read),
      .rdata   (fifo_data),
      .empty   (fifo_empty),
      .full    (fifo_full)
   );

   gpu_inst_regs #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) gpu_inst_regs_i (
      .clk_gpu    (clk_gpu),
      .reset      (reset),
      .fifo_empty (fifo_empty),
      .fifo_full  (fifo_full),
      .fifo_data  (fifo_data),
      .rect_done  (rect_done),
      .fifo_read  (fifo_read),
      .cpu_bp     (cpu_bp),
      .rect_start (rect_start),
      .x1         (x1),
      .y1         (y1),
      .x2         (x2),
      .y2         (y2),
      .color      (color),
      .layer      (layer),
      .cmd_active (cmd_active)
   );

   gpu_draw_rect gpu_draw_rect_i (
      .clk_gpu   (clk_gpu),
      .reset     (reset),
      .pause     (pause),
      .start     (rect_start),
      .x1        (x1),
      .y1        (y1),
      .x2        (x2),
      .y2        (y2),
      .done      (rect_done),
      .pix_valid (pix_valid),
      .pix_x     (pix_x),
      .pix_y     (pix_y)
   );

   gpu_pixel_writer #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) gpu_pixel_writer_i (
      .clk_gpu   (clk_gpu),
      .reset     (reset),
      .pause     (pause),
      .pix_valid (pix_valid),
      .pix_x     (pix_x),
      .pix_y     (pix_y),
      .color     (color),
      .layer     (layer),
      .ram_addr  (ram_addr),
      .ram_wdata (ram_wdata),
      .ram_we_n  (ram_we_n)
   );

endmodule

// File: source/gpu_pixel_writer.sv
`timescale 1ns/1ps

module gpu_pixel_writer #(
   parameter int SCREEN_W = 320,
   parameter int SCREEN_H = 240
) (
   input  logic                         clk_gpu,
   input  logic                         reset,
   input  logic                         pause,
   input  logic                         pix_valid,
   input  logic [gpu_pkg::X_W-1:0]      pix_x,
   input  logic [gpu_pkg::Y_W-1:0]      pix_y,
   input  logic [gpu_pkg::COLOR_W-1:0]  color,
   input  gpu_pkg::gpu_layer_e          layer,
   output logic [gpu_pkg::ADDR_W-1:0]   ram_addr,
   output logic [gpu_pkg::COLOR_W-1:0]  ram_wdata,
   output logic                         ram_we_n
);

   localparam logic [gpu_pkg::ADDR_W-1:0] LINE_LEN  = gpu_pkg::ADDR_W'(SCREEN_W);
   // Foreground plane sits one screen above the background.
   localparam logic [gpu_pkg::ADDR_W-1:0] FG_OFFSET = gpu_pkg::ADDR_W'(SCREEN_W * SCREEN_H);

   logic                        in_screen;
   logic [gpu_pkg::ADDR_W-1:0]  lin_addr;
   logic [gpu_pkg::ADDR_W-1:0]  plane_addr;
   logic [gpu_pkg::ADDR_W-1:0]  addr_q;
   logic [gpu_pkg::COLOR_W-1:0] data_q;
   logic                        we_n_q;

   assign in_screen = (pix_x < SCREEN_W) && (pix_y < SCREEN_H);

   assign lin_addr   = gpu_pkg::ADDR_W'(pix_y) * LINE_LEN + gpu_pkg::ADDR_W'(pix_x);
   assign plane_addr = (layer == gpu_pkg::LAYER_FG) ? lin_addr + FG_OFFSET : lin_addr;

   ////////////////////////////////////////////////////////////
   // Write stage
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_gpu) begin
      if (reset) begin
         we_n_q <= 1'b1;
      end else if (!pause) begin
         we_n_q <= !(pix_valid && in_screen);
      end
   end

   always_ff @(posedge clk_gpu) begin
      if (!pause) begin
         addr_q <= plane_addr;
         data_q <= color;
      end
   end

   // A held write goes out once pause drops.
   assign ram_we_n  = we_n_q || pause;
   assign ram_addr  = addr_q;
   assign ram_wdata = data_q;

endmodule

// File: source/gpu_draw_rect.sv
`timescale 1ns/1ps

module gpu_draw_rect (
   input  logic                    clk_gpu,
   input  logic                    reset,
   input  logic                    pause,
   input  logic                    start,
   input  logic [gpu_pkg::X_W-1:0] x1,
   input  logic [gpu_pkg::Y_W-1:0] y1,
   input  logic [gpu_pkg::X_W-1:0] x2,
   input  logic [gpu_pkg::Y_W-1:0] y2,
   output logic                    done,
   output logic                    pix_valid,
   output logic [gpu_pkg::X_W-1:0] pix_x,
   output logic [gpu_pkg::Y_W-1:0] pix_y
);

   gpu_pkg::rect_state_e    state;
   logic [gpu_pkg::X_W-1:0] x_lo;
   logic [gpu_pkg::X_W-1:0] x_hi;
   logic [gpu_pkg::Y_W-1:0] y_lo;
   logic [gpu_pkg::Y_W-1:0] y_hi;
   logic [gpu_pkg::X_W-1:0] x_min;
   logic [gpu_pkg::X_W-1:0] x_max;
   logic [gpu_pkg::Y_W-1:0] y_max;
   logic                    step;
   logic                    line_end;

   // Corners may come in any order.
   assign x_lo = (x1 < x2) ? x1 : x2;
   assign x_hi = (x1 < x2) ? x2 : x1;
   assign y_lo = (y1 < y2) ? y1 : y2;
   assign y_hi = (y1 < y2) ? y2 : y1;

   assign step      = (state == gpu_pkg::RECT_RUN) && !pause;
   assign line_end  = (pix_x == x_max);
   assign pix_valid = step;
   assign done      = step && line_end && (pix_y == y_max);

   always_ff @(posedge clk_gpu) begin
      if (reset) begin
         state <= gpu_pkg::RECT_IDLE;
      end else if (start) begin
         state <= gpu_pkg::RECT_RUN;
      end else if (done) begin
         state <= gpu_pkg::RECT_IDLE;
      end
   end

   // Raster walk, x first.
   always_ff @(posedge clk_gpu) begin
      if (start) begin
         x_min <= x_lo;
         x_max <= x_hi;
         y_max <= y_hi;
         pix_x <= x_lo;
         pix_y <= y_lo;
      end else if (step && !done) begin
         if (line_end) begin
            pix_x <= x_min;
            pix_y <= pix_y + 1'b1;
         end else begin
            pix_x <= pix_x + 1'b1;
         end
      end
   end

endmodule

// File: source/gpu_inst_regs.sv
`timescale 1ns/1ps

module gpu_inst_regs #(
   parameter int SCREEN_W = 320,
   parameter int SCREEN_H = 240
) (
   input  logic                        clk_gpu,
   input  logic                        reset,
   input  logic                        fifo_empty,
   input  logic                        fifo_full,
   input  logic [gpu_pkg::INST_W-1:0]  fifo_data,
   input  logic                        rect_done,
   output logic                        fifo_read,
   output logic                        cpu_bp,
   output logic                        rect_start,
   output logic [gpu_pkg::X_W-1:0]     x1,
   output logic [gpu_pkg::Y_W-1:0]     y1,
   output logic [gpu_pkg::X_W-1:0]     x2,
   output logic [gpu_pkg::Y_W-1:0]     y2,
   output logic [gpu_pkg::COLOR_W-1:0] color,
   output gpu_pkg::gpu_layer_e         layer,
   output logic                        cmd_active
);

   gpu_pkg::boot_state_e       boot_state;
   gpu_pkg::gpu_cmd_e          cmd;
   gpu_pkg::gpu_layer_e        clr_layer;
   logic [gpu_pkg::COLOR_W-1:0] color_q;
   logic                       busy;
   logic                       done_q;
   logic                       clear_sel;
   logic                       pop;
   logic                       boot_clear;
   logic                       clr_go;
   logic                       draw_go;

   assign cmd = gpu_pkg::gpu_cmd_e'(fifo_data[gpu_pkg::CMD_MSB:gpu_pkg::CMD_LSB]);

   // No pops until both boot clears have finished.
   assign pop        = !fifo_empty && !busy && (boot_state == gpu_pkg::BOOT_DONE);
   assign fifo_read  = pop;
   assign boot_clear = !busy && (boot_state != gpu_pkg::BOOT_DONE);

   assign clr_go  = boot_clear || (pop && cmd == gpu_pkg::CMD_CLEAR);
   assign draw_go = pop && cmd == gpu_pkg::CMD_DRAW_RECT;

   always_comb begin
      if (boot_clear) begin
         clr_layer = (boot_state == gpu_pkg::BOOT_CLEAR_FG) ?
                     gpu_pkg::LAYER_FG : gpu_pkg::LAYER_BG;
      end else begin
         clr_layer = gpu_pkg::gpu_layer_e'(fifo_data[0]);
      end
   end

   assign cpu_bp     = fifo_full || (boot_state != gpu_pkg::BOOT_DONE);
   // Stays up one more cycle to cover the last pixel's write.
   assign cmd_active = busy || done_q || (boot_state != gpu_pkg::BOOT_DONE);

   // Clears draw zero without touching the stored color.
   assign color = clear_sel ? '0 : color_q;

   ////////////////////////////////////////////////////////////
   // Control
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_gpu) begin
      if (reset) begin
         boot_state <= gpu_pkg::BOOT_CLEAR_BG;
         busy       <= 1'b0;
         done_q     <= 1'b0;
         rect_start <= 1'b0;
         clear_sel  <= 1'b0;
      end else begin
         rect_start <= clr_go || draw_go;
         done_q     <= rect_done;

         if (rect_done) begin
            busy <= 1'b0;
         end else if (clr_go || draw_go) begin
            busy <= 1'b1;
         end

         if (clr_go) begin
            clear_sel <= 1'b1;
         end else if (draw_go) begin
            clear_sel <= 1'b0;
         end

         if (rect_done) begin
            case (boot_state)
               gpu_pkg::BOOT_CLEAR_BG: boot_state <= gpu_pkg::BOOT_CLEAR_FG;
               gpu_pkg::BOOT_CLEAR_FG: boot_state <= gpu_pkg::BOOT_DONE;
               default:                boot_state <= gpu_pkg::BOOT_DONE;
            endcase
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Drawing parameters
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_gpu) begin
      if (clr_go) begin
         x1    <= '0;
         y1    <= '0;
         x2    <= gpu_pkg::X_W'(SCREEN_W - 1);
         y2    <= gpu_pkg::Y_W'(SCREEN_H - 1);
         layer <= clr_layer;
      end else if (pop) begin
         case (cmd)
            gpu_pkg::CMD_SET_P1: begin
               x1 <= fifo_data[gpu_pkg::P_X_MSB:gpu_pkg::P_X_LSB];
               y1 <= fifo_data[gpu_pkg::P_Y_MSB:gpu_pkg::P_Y_LSB];
            end
            gpu_pkg::CMD_SET_P2: begin
               x2 <= fifo_data[gpu_pkg::P_X_MSB:gpu_pkg::P_X_LSB];
               y2 <= fifo_data[gpu_pkg::P_Y_MSB:gpu_pkg::P_Y_LSB];
            end
            gpu_pkg::CMD_SET_COLOR: color_q <= fifo_data[gpu_pkg::COLOR_W-1:0];
            gpu_pkg::CMD_SET_LAYER: layer <= gpu_pkg::gpu_layer_e'(fifo_data[0]);
            default: ;
         endcase
      end
   end

endmodule

// File: source/gpu_inst_fifo.sv
`timescale 1ns/1ps

module gpu_inst_fifo #(
   parameter int FIFO_DEPTH = 64
) (
   input  logic                       clk_gpu,
   input  logic                       reset,
   input  logic                       write,
   input  logic [gpu_pkg::INST_W-1:0] wdata,
   input  logic                       read,
   output logic [gpu_pkg::INST_W-1:0] rdata,
   output logic                       empty,
   output logic                       full
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   logic [gpu_pkg::INST_W-1:0] mem [FIFO_DEPTH];
   logic [PTR_W-1:0]           wr_ptr;
   logic [PTR_W-1:0]           rd_ptr;
   logic [CNT_W-1:0]           count;
   logic                       do_wr;
   logic                       do_rd;

   assign do_wr = write && !full;
   assign do_rd = read && !empty;

   assign empty = (count == '0);
   assign full  = (count == CNT_W'(FIFO_DEPTH));

   // Head entry is always visible.
   assign rdata = mem[rd_ptr];

   always_ff @(posedge clk_gpu) begin
      if (do_wr) begin
         mem[wr_ptr] <= wdata;
      end
   end

   always_ff @(posedge clk_gpu) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (do_wr && !do_rd) begin
            count <= count + 1'b1;
         end else if (do_rd && !do_wr) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

// File: source/gpu_pkg.sv
package gpu_pkg;

   ////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////

   localparam int INST_W  = 30;
   localparam int X_W     = 9;
   localparam int Y_W     = 8;
   localparam int ADDR_W  = 18;
   localparam int COLOR_W = 16;

   ////////////////////////////////////////////////////////////
   // Instruction fields
   ////////////////////////////////////////////////////////////

   localparam int CMD_MSB = 29;
   localparam int CMD_LSB = 26;

   // Point payload of SET_P1 and SET_P2.
   localparam int P_X_MSB = 16;
   localparam int P_X_LSB = 8;
   localparam int P_Y_MSB = 7;
   localparam int P_Y_LSB = 0;

   typedef enum logic [3:0] {
      CMD_NOP       = 4'd0,
      CMD_SET_P1    = 4'd1,
      CMD_SET_P2    = 4'd2,
      CMD_SET_COLOR = 4'd3,
      CMD_SET_LAYER = 4'd4,
      CMD_CLEAR     = 4'd5,
      CMD_DRAW_RECT = 4'd6
   } gpu_cmd_e;

   typedef enum logic {
      LAYER_BG = 1'b0,
      LAYER_FG = 1'b1
   } gpu_layer_e;

   ////////////////////////////////////////////////////////////
   // FSM states
   ////////////////////////////////////////////////////////////

   typedef enum logic {
      RECT_IDLE,
      RECT_RUN
   } rect_state_e;

   typedef enum logic [1:0] {
      BOOT_CLEAR_BG,
      BOOT_CLEAR_FG,
      BOOT_DONE
   } boot_state_e;

endpackage
